// File: design/fpMul_cfg.svh
`ifndef FPMUL_CFG_SVH
`define FPMUL_CFG_SVH

// Cycles from an accepted operand pair to outValid
`define FPM_LATENCY 8

// APB register map
`define FPM_ADDR_CTRL   8'h00
`define FPM_ADDR_STATUS 8'h04
`define FPM_ADDR_COUNT  8'h08

// Result counter width
`define FPM_CNT_WIDTH 16

// Canonical quiet NaN
`define FPM_QNAN 32'h7FC00000

`endif

// File: design/fpMulPkg.sv
`include "fpMul_cfg.svh"

package fpMulPkg;

	typedef logic [7:0] expT;
	typedef logic [22:0] manT;
	typedef logic [23:0] sigT;
	typedef logic [47:0] prodT;
	typedef logic signed [9:0] wideExpT;
	typedef logic [`FPM_CNT_WIDTH-1:0] cntT;

	// IEEE-754 single precision word
	typedef struct packed {
		logic sign;
		expT  exponent;
		manT  fraction;
	} fpWordT;

	// Bit order matches STATUS bits 2:0 and CTRL mask bits 3:1
	typedef struct packed {
		logic invalid;
		logic overflow;
		logic zero;
	} excFlagsT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apbReqT;

endpackage

// File: design/fpMulRegs.sv
`timescale 1ns/100ps
`include "fpMul_cfg.svh"

module fpMulRegs (
	input  logic               CLK,
	input  logic               RST,
	input  fpMulPkg::apbReqT   apbReq,
	output logic [31:0]        prdata,
	output logic               pslverr,
	input  fpMulPkg::excFlagsT flags,
	input  logic               outValid,
	output logic               enable,
	output logic               irq
);
	import fpMulPkg::*;

	logic       access;
	logic       wrEn;
	logic       mapped;
	logic [2:0] intMask;
	excFlagsT   sticky;
	excFlagsT   stickyClr;
	excFlagsT   stickySet;
	cntT        resCount;

	// Transfers complete in the access phase, no wait states
	assign access = apbReq.psel & apbReq.penable;
	assign wrEn = access & apbReq.pwrite;

	always_comb
	begin
		mapped = 1'b1;
		prdata = '0;
		case (apbReq.paddr)
			`FPM_ADDR_CTRL:   prdata = {28'd0, intMask, enable};
			`FPM_ADDR_STATUS: prdata = {29'd0, sticky};
			`FPM_ADDR_COUNT:  prdata = {{(32 - `FPM_CNT_WIDTH){1'b0}}, resCount};
			default:          mapped = 1'b0;
		endcase
		if (!access || apbReq.pwrite)
		begin
			prdata = '0;
		end
	end

	assign pslverr = access & !mapped;

	// Write one to clear, a new flag in the same cycle wins
	assign stickyClr = (wrEn && apbReq.paddr == `FPM_ADDR_STATUS) ?
		excFlagsT'(apbReq.pwdata[2:0]) : excFlagsT'(3'b000);
	assign stickySet = outValid ? flags : excFlagsT'(3'b000);

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			enable <= 1'b0;
			intMask <= '0;
		end
		else if (wrEn && apbReq.paddr == `FPM_ADDR_CTRL)
		begin
			enable <= apbReq.pwdata[0];
			intMask <= apbReq.pwdata[3:1];
		end
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			sticky <= '0;
			irq <= 1'b0;
		end
		else
		begin
			sticky <= excFlagsT'((sticky & ~stickyClr) | stickySet);
			irq <= |(sticky & intMask);
		end
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			resCount <= '0;
		end
		else if (wrEn && apbReq.paddr == `FPM_ADDR_COUNT)
		begin
			resCount <= '0;
		end
		else if (outValid)
		begin
			resCount <= resCount + 1'b1;
		end
	end

endmodule

// File: design/sigMulPipe.sv
`timescale 1ns/100ps

module sigMulPipe (
	input  logic              CLK,
	input  logic              RST,
	input  fpMulPkg::fpWordT  opA,
	input  fpMulPkg::fpWordT  opB,
	input  logic              inValid,
	input  logic              enable,
	output fpMulPkg::prodT    product,
	output fpMulPkg::wideExpT expSum,
	output logic              sign,
	output logic              valid
);
	import fpMulPkg::*;

	localparam int chunkW = 6;

	typedef struct packed {
		sigT     sigA;
		sigT     sigB;
		prodT    acc;
		wideExpT expSum;
		logic    sign;
	} stageT;

	fpWordT     aReg;
	fpWordT     bReg;
	sigT        sigA1;
	sigT        sigB1;
	wideExpT    expSum1;
	logic       sign1;
	logic [4:0] validPipe;
	stageT      stg [2:5];

	// One 24x6 slice of the significand product, placed at its weight
	function automatic prodT partial(input sigT a, input sigT b, input int unsigned k);
		prodT p;
		p = prodT'(a) * prodT'(b[chunkW * k +: chunkW]);
		return p << (chunkW * k);
	endfunction

	// Hidden bit restored for any nonzero exponent
	assign sigA1 = {|aReg.exponent, aReg.fraction};
	assign sigB1 = {|bReg.exponent, bReg.fraction};
	assign expSum1 = wideExpT'({2'b00, aReg.exponent}) + wideExpT'({2'b00, bReg.exponent})
		- 10'sd127;
	assign sign1 = aReg.sign ^ bReg.sign;

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[3:0], inValid & enable};
		end
	end

	always_ff @(posedge CLK)
	begin
		aReg <= opA;
		bReg <= opB;
		stg[2].sigA <= sigA1;
		stg[2].sigB <= sigB1;
		stg[2].acc <= partial(sigA1, sigB1, 0);
		stg[2].expSum <= expSum1;
		stg[2].sign <= sign1;
		// Stages 3 to 5 each add one more slice
		for (int k = 3; k <= 5; k++)
		begin
			stg[k].sigA <= stg[k-1].sigA;
			stg[k].sigB <= stg[k-1].sigB;
			stg[k].acc <= stg[k-1].acc + partial(stg[k-1].sigA, stg[k-1].sigB, k - 2);
			stg[k].expSum <= stg[k-1].expSum;
			stg[k].sign <= stg[k-1].sign;
		end
	end

	assign product = stg[5].acc;
	assign expSum = stg[5].expSum;
	assign sign = stg[5].sign;
	assign valid = validPipe[4];

endmodule

// File: design/fpNormRound.sv
`timescale 1ns/100ps

module fpNormRound (
	input  logic              CLK,
	input  logic              RST,
	input  fpMulPkg::prodT    product,
	input  fpMulPkg::wideExpT expSum,
	input  logic              sign,
	input  logic              validIn,
	output fpMulPkg::fpWordT  res,
	output logic              overflowCase,
	output logic              underflowCase,
	output logic              valid
);
	import fpMulPkg::*;

	logic        topBit;
	manT         manRaw;
	logic        guardBit;
	logic        roundBit;
	logic        stickyBit;
	logic        roundUp;
	logic [23:0] manInc;
	wideExpT     expAdj;
	wideExpT     expFinal;

	always_comb
	begin
		// Product of two normals lies in [1,4)
		topBit = product[47];
		if (topBit)
		begin
			manRaw = product[46:24];
			guardBit = product[23];
			roundBit = product[22];
			stickyBit = |product[21:0];
		end
		else
		begin
			manRaw = product[45:23];
			guardBit = product[22];
			roundBit = product[21];
			stickyBit = |product[20:0];
		end
		// Ties go to the even neighbour
		roundUp = guardBit & (roundBit | stickyBit | manRaw[0]);
		manInc = {1'b0, manRaw} + 24'(roundUp);
		expAdj = expSum + wideExpT'({9'd0, topBit});
		// Carry out of the fraction bumps the exponent, fraction is then zero
		expFinal = expAdj + wideExpT'({9'd0, manInc[23]});
	end

	always_ff @(posedge CLK)
	begin
		res.sign <= sign;
		res.exponent <= expFinal[7:0];
		res.fraction <= manInc[22:0];
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			overflowCase <= 1'b0;
			underflowCase <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			overflowCase <= (expFinal >= 10'sd255);
			underflowCase <= (expFinal <= 10'sd0);
			valid <= validIn;
		end
	end

endmodule

// File: design/excDetect.sv
`timescale 1ns/100ps
`include "fpMul_cfg.svh"

module excDetect (
	input  logic               CLK,
	input  logic               RST,
	input  fpMulPkg::fpWordT   opA,
	input  fpMulPkg::fpWordT   opB,
	input  fpMulPkg::fpWordT   res,
	input  logic               overflowCase,
	input  logic               underflowCase,
	input  logic               validIn,
	output fpMulPkg::fpWordT   result,
	output fpMulPkg::excFlagsT flags,
	output logic               outValid
);
	import fpMulPkg::*;

	// Operands meet the normalized result one stage before the output
	localparam int opDelay = `FPM_LATENCY - 1;

	fpWordT   aDly [1:opDelay];
	fpWordT   bDly [1:opDelay];
	fpWordT   resQ;
	logic     ovfQ;
	logic     unfQ;
	logic     validQ;
	logic     xZero;
	logic     yZero;
	logic     xInf;
	logic     yInf;
	logic     xNan;
	logic     yNan;
	logic     resInf;
	excFlagsT flagsNext;
	fpWordT   resultNext;

	function automatic logic isZero(input fpWordT w);
		return (w.exponent == '0) && (w.fraction == '0);
	endfunction

	function automatic logic isInf(input fpWordT w);
		return (&w.exponent) && (w.fraction == '0);
	endfunction

	function automatic logic isNan(input fpWordT w);
		return (&w.exponent) && (w.fraction != '0);
	endfunction

	always_ff @(posedge CLK)
	begin
		aDly[1] <= opA;
		bDly[1] <= opB;
		for (int i = 2; i <= opDelay; i++)
		begin
			aDly[i] <= aDly[i-1];
			bDly[i] <= bDly[i-1];
		end
		resQ <= res;
		ovfQ <= overflowCase;
		unfQ <= underflowCase;
	end

	assign xZero = isZero(aDly[opDelay]);
	assign yZero = isZero(bDly[opDelay]);
	assign xInf = isInf(aDly[opDelay]);
	assign yInf = isInf(bDly[opDelay]);
	assign xNan = isNan(aDly[opDelay]);
	assign yNan = isNan(bDly[opDelay]);
	assign resInf = isInf(resQ);

	always_comb
	begin
		flagsNext.invalid = xNan | yNan | (xZero & yInf) | (xInf & yZero);
		flagsNext.overflow = resInf | (xInf & !yZero) | (!xZero & yInf) | ovfQ;
		flagsNext.zero = (xZero & !yInf) | (!xInf & yZero);

		resultNext = resQ;
		if (flagsNext.invalid)
		begin
			resultNext = fpWordT'(`FPM_QNAN);
		end
		else if (flagsNext.overflow)
		begin
			resultNext.exponent = '1;
			resultNext.fraction = '0;
		end
		else if (flagsNext.zero || unfQ)
		begin
			// Underflow flushes to signed zero without a flag
			resultNext.exponent = '0;
			resultNext.fraction = '0;
		end
	end

	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			validQ <= 1'b0;
			outValid <= 1'b0;
			result <= '0;
			flags <= '0;
		end
		else
		begin
			validQ <= validIn;
			outValid <= validQ;
			result <= resultNext;
			flags <= flagsNext;
		end
	end

endmodule

// File: design/fpMulTop.sv
`timescale 1ns/100ps

module fpMulTop (
	input  logic               CLK,
	input  logic               RST,
	input  fpMulPkg::apbReqT   apbReq,
	output logic [31:0]        prdata,
	output logic               pslverr,
	input  fpMulPkg::fpWordT   opA,
	input  fpMulPkg::fpWordT   opB,
	input  logic               inValid,
	output fpMulPkg::fpWordT   result,
	output fpMulPkg::excFlagsT flags,
	output logic               outValid,
	output logic               irq
);
	import fpMulPkg::*;

	logic    enable;
	prodT    product;
	wideExpT expSum;
	logic    prodSign;
	logic    mulValid;
	fpWordT  normRes;
	logic    overflowCase;
	logic    underflowCase;
	logic    normValid;

	fpMulRegs i_fpMulRegs (
		.CLK      (CLK),
		.RST      (RST),
		.apbReq   (apbReq),
		.prdata   (prdata),
		.pslverr  (pslverr),
		.flags    (flags),
		.outValid (outValid),
		.enable   (enable),
		.irq      (irq)
	);

	sigMulPipe i_sigMulPipe (
		.CLK     (CLK),
		.RST     (RST),
		.opA     (opA),
		.opB     (opB),
		.inValid (inValid),
		.enable  (enable),
		.product (product),
		.expSum  (expSum),
		.sign    (prodSign),
		.valid   (mulValid)
	);

	fpNormRound i_fpNormRound (
		.CLK           (CLK),
		.RST           (RST),
		.product       (product),
		.expSum        (expSum),
		.sign          (prodSign),
		.validIn       (mulValid),
		.res           (normRes),
		.overflowCase  (overflowCase),
		.underflowCase (underflowCase),
		.valid         (normValid)
	);

	excDetect i_excDetect (
		.CLK           (CLK),
		.RST           (RST),
		.opA           (opA),
		.opB           (opB),
		.res           (normRes),
		.overflowCase  (overflowCase),
		.underflowCase (underflowCase),
		.validIn       (normValid),
		.result        (result),
		.flags         (flags),
		.outValid      (outValid)
	);

endmodule

// File: test/fpMulTb_checker.sv
`timescale 1ns/100ps
`include "fpMul_cfg.svh"

module fpMulTb_checker (
	input logic               CLK,
	input logic               RST,
	input fpMulPkg::apbReqT   apbReq,
	input fpMulPkg::fpWordT   opA,
	input fpMulPkg::fpWordT   opB,
	input logic               inValid,
	input logic               enable,
	input logic               outValid,
	input logic               irq,
	input fpMulPkg::fpWordT   result,
	input fpMulPkg::excFlagsT flags
);
	import fpMulPkg::*;

	excFlagsT   stickyRef;
	logic [2:0] maskRef;
	logic       ctrlWr;
	logic       statusWr;

	// NaN operand, or zero times infinity
	function automatic logic invalidPair(input fpWordT a, input fpWordT b);
		logic aNan;
		logic bNan;
		logic aZero;
		logic bZero;
		logic aInf;
		logic bInf;
		aNan = (a.exponent == 8'hFF) && (a.fraction != '0);
		bNan = (b.exponent == 8'hFF) && (b.fraction != '0);
		aInf = (a.exponent == 8'hFF) && (a.fraction == '0);
		bInf = (b.exponent == 8'hFF) && (b.fraction == '0);
		aZero = (a.exponent == 8'h00) && (a.fraction == '0);
		bZero = (b.exponent == 8'h00) && (b.fraction == '0);
		return aNan | bNan | (aZero & bInf) | (aInf & bZero);
	endfunction

	assign ctrlWr = apbReq.psel && apbReq.penable && apbReq.pwrite
		&& apbReq.paddr == `FPM_ADDR_CTRL;
	assign statusWr = apbReq.psel && apbReq.penable && apbReq.pwrite
		&& apbReq.paddr == `FPM_ADDR_STATUS;

	// Sticky flags and interrupt mask as seen from the bus and the result port
	always_ff @(posedge CLK or negedge RST)
	begin
		if (!RST)
		begin
			stickyRef <= '0;
			maskRef <= '0;
		end
		else
		begin
			if (ctrlWr)
				maskRef <= apbReq.pwdata[3:1];
			for (int i = 0; i < 3; i++)
			begin
				if (outValid && flags[i])
					stickyRef[i] <= 1'b1;
				else if (statusWr && apbReq.pwdata[i])
					stickyRef[i] <= 1'b0;
			end
		end
	end

	// Every accepted pair shows up exactly once, a fixed latency later
	latencyCheck: assert property (@(posedge CLK) disable iff (!RST)
		outValid == $past(inValid && enable, `FPM_LATENCY))
		else $error("outValid not %0d cycles after an accepted input", `FPM_LATENCY);

	// Invalid pairs come out as the canonical NaN, and nothing else raises invalid
	nanCheck: assert property (@(posedge CLK) disable iff (!RST)
		outValid |-> (flags.invalid == $past(invalidPair(opA, opB), `FPM_LATENCY))
			&& (!flags.invalid || result == `FPM_QNAN))
		else $error("invalid flag or NaN result does not match the operands, result %h", result);

	// irq is registered from the sticky bits and the mask
	irqCheck: assert property (@(posedge CLK) disable iff (!RST)
		irq == $past(|(stickyRef & maskRef)))
		else $error("irq does not match sticky flags and mask");

endmodule

bind fpMulTop fpMulTb_checker i_fpMulTb_checker (
	.CLK      (CLK),
	.RST      (RST),
	.apbReq   (apbReq),
	.opA      (opA),
	.opB      (opB),
	.inValid  (inValid),
	.enable   (enable),
	.outValid (outValid),
	.irq      (irq),
	.result   (result),
	.flags    (flags)
);

// File: test/fpMulTb.sv
`timescale 1ns/100ps
`include "fpMul_cfg.svh"

module fpMulTb;
	import fpMulPkg::*;

	typedef struct packed {
		fpWordT   res;
		excFlagsT flg;
	} expEntryT;

	typedef struct packed {
		fpWordT   a;
		fpWordT   b;
		expEntryT want;
	} vecT;

	localparam int nTab = 20;
	localparam int nRand = 200;
	// Issue and drain of every pair twice over, plus room for APB traffic and waits
	localparam int cycleLimit = 2 * (nTab + nRand + `FPM_LATENCY) + 300;

	logic        CLK = 1'b0;
	logic        RST;
	apbReqT      apbReq;
	logic [31:0] prdata;
	logic        pslverr;
	fpWordT      opA;
	fpWordT      opB;
	logic        inValid;
	fpWordT      result;
	excFlagsT    flags;
	logic        outValid;
	logic        irq;
	expEntryT    expQ [$];
	int          errors = 0;
	int          resultCount = 0;
	int          testCount = 0;
	int          cycleCount = 0;

	// Operand A, operand B, expected result, expected flags {invalid, overflow, zero}
	vecT vecs [0:nTab-1] = '{
		{32'h3FC00000, 32'h40000000, 32'h40400000, 3'b000},
		{32'h3F800000, 32'h3F800000, 32'h3F800000, 3'b000},
		{32'hC0000000, 32'h40400000, 32'hC0C00000, 3'b000},
		{32'h3FC00000, 32'h3FC00000, 32'h40100000, 3'b000},
		{32'h3F800001, 32'h3FC00000, 32'h3FC00002, 3'b000},
		{32'h3F800003, 32'h3FC00000, 32'h3FC00004, 3'b000},
		{32'h3F800001, 32'h3F800001, 32'h3F800002, 3'b000},
		{32'h7F7FFFFF, 32'h3F800000, 32'h7F7FFFFF, 3'b000},
		{32'h7F7FFFFF, 32'h3F800001, 32'h7F800000, 3'b010},
		{32'h7FC00000, 32'h3A800000, 32'h7FC00000, 3'b100},
		{32'h7F800001, 32'hBA800000, 32'h7FC00000, 3'b100},
		{32'h00000000, 32'h7F800000, 32'h7FC00000, 3'b100},
		{32'hFF800000, 32'h7F800000, 32'hFF800000, 3'b010},
		{32'h7F800000, 32'hC0000000, 32'hFF800000, 3'b010},
		{32'h80000000, 32'h40400000, 32'h80000000, 3'b001},
		{32'h3F800000, 32'h00000000, 32'h00000000, 3'b001},
		{32'h71800000, 32'h71800000, 32'h7F800000, 3'b010},
		{32'hF1800000, 32'h71800000, 32'hFF800000, 3'b010},
		{32'h0D800000, 32'h0D800000, 32'h00000000, 3'b000},
		{32'h8D800000, 32'h0D800000, 32'h80000000, 3'b000}
	};

	fpMulTop i_fpMulTop (.*);

	always #5 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, results never drained", cycleCount);
			$display("Testbench failed");
			$finish;
		end
	end

	always @(negedge CLK)
	begin
		expEntryT e;
		if (outValid && expQ.size() == 0)
		begin
			$display("Unexpected outValid at %0t ns with no operand pair outstanding", $time);
			errors++;
		end
		else if (outValid)
		begin
			e = expQ.pop_front();
			resultCount++;
			if (result !== e.res || flags !== e.flg)
			begin
				$display("[FAIL] %0t ns: result %h flags %b, expected %h flags %b",
					$time, result, flags, e.res, e.flg);
				errors++;
			end
		end
	end

	// Round to nearest even by comparing the dropped bits with one half
	function automatic expEntryT mulModel(input fpWordT a, input fpWordT b);
		expEntryT e;
		longint unsigned p;
		longint unsigned mant;
		longint unsigned rest;
		longint unsigned half;
		int ex;
		int sh;
		p = {40'd0, 1'b1, a.fraction} * {40'd0, 1'b1, b.fraction};
		ex = int'(a.exponent) + int'(b.exponent) - 127;
		sh = p[47] ? 24 : 23;
		ex = ex + (sh - 23);
		mant = p >> sh;
		rest = p & ((64'd1 << sh) - 64'd1);
		half = 64'd1 << (sh - 1);
		if (rest > half || (rest == half && mant[0]))
			mant = mant + 64'd1;
		if (mant[24])
		begin
			mant = mant >> 1;
			ex = ex + 1;
		end
		e = '0;
		e.res.sign = a.sign ^ b.sign;
		if (ex >= 255)
		begin
			e.res.exponent = '1;
			e.flg.overflow = 1'b1;
		end
		else
		begin
			e.res.exponent = ex[7:0];
			e.res.fraction = mant[22:0];
		end
		return e;
	endfunction

	function automatic fpWordT randNormal();
		fpWordT w;
		logic [31:0] r;
		r = $urandom();
		w.sign = r[31];
		w.fraction = r[22:0];
		w.exponent = 8'(64 + ($urandom() % 127));
		return w;
	endfunction

	task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge CLK);
		apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
		@(posedge CLK);
		apbReq.penable <= 1'b1;
		@(negedge CLK);
		rdata = prdata;
		err = pslverr;
		@(posedge CLK);
		apbReq <= '0;
	endtask

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata);
		logic [31:0] rd;
		logic err;
		apbXfer(1'b1, addr, wdata, rd, err);
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata);
		logic err;
		apbXfer(1'b0, addr, 32'd0, rdata, err);
	endtask

	task automatic issueOp(input fpWordT a, input fpWordT b, input logic track, input expEntryT e);
		@(posedge CLK);
		opA <= a;
		opB <= b;
		inValid <= 1'b1;
		if (track)
			expQ.push_back(e);
	endtask

	task automatic finishIssue();
		@(posedge CLK);
		inValid <= 1'b0;
		while (expQ.size() != 0)
			@(negedge CLK);
	endtask

	task automatic valueMismatch(input string what, input logic [31:0] got, input logic [31:0] want);
		$display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, want);
		errors++;
	endtask

	task automatic reportTest(input string name, input int errStart);
		testCount++;
		$display("Test %-10s %s", name, (errors == errStart) ? "ok" : "had errors");
	endtask

	initial
	begin
		logic [31:0] rd;
		logic [31:0] cntSave;
		logic err;
		int errStart;
		fpWordT a;
		fpWordT b;
		void'($urandom(66539));
		RST = 1'b0;
		apbReq = '0;
		opA = '0;
		opB = '0;
		inValid = 1'b0;
		repeat (5) @(posedge CLK);
		RST <= 1'b1;

		errStart = errors;
		apbWrite(`FPM_ADDR_CTRL, 32'h1);
		for (int i = 0; i < nTab; i++)
			issueOp(vecs[i].a, vecs[i].b, 1'b1, vecs[i].want);
		finishIssue();
		apbRead(`FPM_ADDR_COUNT, rd);
		if (rd !== 32'(nTab))
			valueMismatch("COUNT after table", rd, 32'(nTab));
		reportTest("table", errStart);

		errStart = errors;
		apbWrite(`FPM_ADDR_CTRL, 32'h1);
		for (int i = 0; i < nRand; i++)
		begin
			a = randNormal();
			b = randNormal();
			issueOp(a, b, 1'b1, mulModel(a, b));
		end
		finishIssue();
		apbRead(`FPM_ADDR_COUNT, rd);
		if (rd !== 32'(nTab + nRand))
			valueMismatch("COUNT after random", rd, 32'(nTab + nRand));
		reportTest("random", errStart);

		// Table hits all three flags, so every sticky bit is set by now
		errStart = errors;
		apbRead(`FPM_ADDR_STATUS, rd);
		if (rd !== 32'h7)
			valueMismatch("STATUS", rd, 32'h7);
		apbWrite(`FPM_ADDR_STATUS, 32'h2);
		apbRead(`FPM_ADDR_STATUS, rd);
		if (rd !== 32'h5)
			valueMismatch("STATUS after clearing overflow", rd, 32'h5);
		apbWrite(`FPM_ADDR_STATUS, 32'h5);
		apbRead(`FPM_ADDR_STATUS, rd);
		if (rd !== 32'h0)
			valueMismatch("STATUS after clearing all", rd, 32'h0);
		apbRead(`FPM_ADDR_COUNT, rd);
		if (rd !== 32'(nTab + nRand))
			valueMismatch("COUNT", rd, 32'(nTab + nRand));
		apbWrite(`FPM_ADDR_COUNT, 32'h0);
		apbRead(`FPM_ADDR_COUNT, rd);
		if (rd !== 32'h0)
			valueMismatch("COUNT after clear", rd, 32'h0);
		reportTest("registers", errStart);

		// Only the zero flag may raise irq
		errStart = errors;
		apbWrite(`FPM_ADDR_CTRL, 32'h3);
		issueOp(32'h71800000, 32'h71800000, 1'b1, {32'h7F800000, 3'b010});
		finishIssue();
		repeat (3) @(negedge CLK);
		if (irq !== 1'b0)
			valueMismatch("irq for masked overflow", 32'(irq), 32'h0);
		issueOp(32'h00000000, 32'h40400000, 1'b1, {32'h00000000, 3'b001});
		finishIssue();
		repeat (3) @(negedge CLK);
		if (irq !== 1'b1)
			valueMismatch("irq for unmasked zero", 32'(irq), 32'h1);
		apbWrite(`FPM_ADDR_STATUS, 32'h7);
		repeat (3) @(negedge CLK);
		if (irq !== 1'b0)
			valueMismatch("irq after STATUS clear", 32'(irq), 32'h0);
		reportTest("interrupt", errStart);

		errStart = errors;
		apbWrite(`FPM_ADDR_CTRL, 32'h0);
		apbRead(`FPM_ADDR_COUNT, cntSave);
		for (int i = 0; i < 4; i++)
			issueOp(32'h3FC00000, 32'h40000000, 1'b0, '0);
		finishIssue();
		repeat (`FPM_LATENCY + 4) @(negedge CLK);
		apbRead(`FPM_ADDR_COUNT, rd);
		if (rd !== cntSave)
			valueMismatch("COUNT while disabled", rd, cntSave);
		reportTest("disable", errStart);

		errStart = errors;
		apbXfer(1'b0, 8'h0C, 32'h0, rd, err);
		if (err !== 1'b1)
			valueMismatch("pslverr on unmapped read", 32'(err), 32'h1);
		apbXfer(1'b1, 8'h10, 32'hFFFF, rd, err);
		if (err !== 1'b1)
			valueMismatch("pslverr on unmapped write", 32'(err), 32'h1);
		apbXfer(1'b0, `FPM_ADDR_CTRL, 32'h0, rd, err);
		if (err !== 1'b0)
			valueMismatch("pslverr on CTRL read", 32'(err), 32'h0);
		reportTest("apb error", errStart);

		$display("Tests %0d, results checked %0d, errors %0d", testCount, resultCount, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+design
design/fpMulPkg.sv
design/fpMulRegs.sv
design/sigMulPipe.sv
design/fpNormRound.sv
design/excDetect.sv
design/fpMulTop.sv
test/fpMulTb_checker.sv
test/fpMulTb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, and decide the outcome from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fpMulTb \
	-f sim.f -o fpMulSim \
	&& ./obj_dir/fpMulSim 2>&1 | tee sim.log \
	|| { echo "Build or run error"; exit 1; }

grep -q "^Testbench passed$" sim.log \
	&& { echo "Simulation PASS"; exit 0; } \
	|| { echo "Simulation FAIL"; exit 1; }
